/* wb_test_gen.f */
+incdir+verif
hw/wb_test_gen_pkg.sv
hw/test_pattern_gen.sv
hw/test_gen_fifo.sv
hw/wb_burst_read_slave.sv
hw/wb_test_gen_top.sv
verif/tb_wb_test_gen.sv

/* Bender.yml */
package:
  name: wb_test_gen

sources:
  # RTL in compile order
  - hw/wb_test_gen_pkg.sv
  - hw/test_pattern_gen.sv
  - hw/test_gen_fifo.sv
  - hw/wb_burst_read_slave.sv
  - hw/wb_test_gen_top.sv
  # Testbench
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_wb_test_gen.sv

/* verif/tb_wb_test_gen_table.svh */
`ifndef TB_WB_TEST_GEN_TABLE_SVH
`define TB_WB_TEST_GEN_TABLE_SVH

//////////////////////////////////////////////////////////////////////
// Burst styles for the bus master
//////////////////////////////////////////////////////////////////////
localparam logic [2:0] STYLE_NORMAL    = 3'd0;
localparam logic [2:0] STYLE_STB_GAP   = 3'd1;   // One stb low cycle mid-burst
localparam logic [2:0] STYLE_EARLY_EOB = 3'd2;   // EOB from a random beat on
localparam logic [2:0] STYLE_NO_EOB    = 3'd3;   // CONST kept on last beat
localparam logic [2:0] STYLE_BAD_SEL   = 3'd4;   // Partial byte select

localparam logic       M_CNT    = wb_test_gen_pkg::GEN_MODE_COUNT;
localparam logic       M_LFSR   = wb_test_gen_pkg::GEN_MODE_LFSR;
localparam logic [7:0] ACKS_ALL = 8'(wb_test_gen_pkg::BURST_LEN);

typedef struct packed
{
    logic        clear;         // Pulse clear before the burst
    logic        mode;          // Taken by the generator on clear
    logic [2:0]  style;
    logic [7:0]  pause_max;     // Longest generator off time, 0 for none
    logic [15:0] idle;          // Idle cycles ahead of the burst
    logic [7:0]  exp_acks;
    logic        exp_err;
} row_t;

localparam int NUM_ROWS = 13;

// One row per burst
function automatic row_t table_row(input int idx);
    // Columns: clear, mode, style, pause max, idle, expected acks, expected err
    case (idx)
        0:  table_row = {1'b1, M_CNT,  STYLE_NORMAL,    8'd0,  16'd0,   ACKS_ALL, 1'b0};
        1:  table_row = {1'b0, M_CNT,  STYLE_NORMAL,    8'd0,  16'd0,   ACKS_ALL, 1'b0};
        2:  table_row = {1'b1, M_LFSR, STYLE_NORMAL,    8'd0,  16'd0,   ACKS_ALL, 1'b0};
        3:  table_row = {1'b0, M_LFSR, STYLE_NORMAL,    8'd0,  16'd0,   ACKS_ALL, 1'b0};
        4:  table_row = {1'b1, M_CNT,  STYLE_NORMAL,    8'd20, 16'd0,   ACKS_ALL, 1'b0};
        5:  table_row = {1'b1, M_LFSR, STYLE_NORMAL,    8'd30, 16'd0,   ACKS_ALL, 1'b0};
        6:  table_row = {1'b1, M_CNT,  STYLE_STB_GAP,   8'd0,  16'd0,   ACKS_ALL, 1'b1};
        7:  table_row = {1'b1, M_CNT,  STYLE_EARLY_EOB, 8'd0,  16'd0,   ACKS_ALL, 1'b1};
        8:  table_row = {1'b1, M_LFSR, STYLE_NO_EOB,    8'd0,  16'd0,   ACKS_ALL, 1'b1};
        9:  table_row = {1'b1, M_CNT,  STYLE_BAD_SEL,   8'd0,  16'd0,   8'd0,     1'b0};
        10: table_row = {1'b1, M_CNT,  STYLE_NORMAL,    8'd0,  16'd0,   ACKS_ALL, 1'b0};
        11: table_row = {1'b0, M_CNT,  STYLE_NORMAL,    8'd0,  16'd300, ACKS_ALL, 1'b0};
        12: table_row = {1'b0, M_CNT,  STYLE_NORMAL,    8'd0,  16'd0,   ACKS_ALL, 1'b0};
        default: table_row = '0;
    endcase
endfunction

`endif

/* verif/tb_wb_test_gen.sv */
`default_nettype none

module tb_wb_test_gen;

    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_wb_test_gen_table.svh"

    localparam int BURST_LEN   = wb_test_gen_pkg::BURST_LEN;
    localparam int CYCLE_LIMIT = NUM_ROWS * (4 * BURST_LEN + 200);   // Whole run budget

    logic                                  clk = 1'b0;
    logic                                  rst;
    logic                                  gen_en;
    logic                                  gen_clear;
    logic                                  gen_mode;
    logic [wb_test_gen_pkg::ADDR_W-1:0]    wb_addr;
    logic [wb_test_gen_pkg::SEL_W-1:0]     wb_sel;
    logic                                  wb_we;
    logic                                  wb_cyc;
    logic                                  wb_stb;
    logic [2:0]                            wb_cti;
    logic [1:0]                            wb_bte;
    logic [wb_test_gen_pkg::DATA_W-1:0]    wb_data;
    logic                                  wb_ack;
    logic                                  wb_err;
    logic                                  fifo_full;

    logic [wb_test_gen_pkg::DATA_W-1:0]    exp_word;            // Next word the model expects
    logic                                  exp_mode;
    logic [31:0]                           rng = 32'h63f8f405;
    int                                    cycle_cnt = 0;
    row_t                                  row;

    wb_test_gen_top UUT
    (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_gen_en    (gen_en),
        .i_gen_clear (gen_clear),
        .i_gen_mode  (gen_mode),
        .i_wb_addr   (wb_addr),
        .i_wb_sel    (wb_sel),
        .i_wb_we     (wb_we),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_cti    (wb_cti),
        .i_wb_bte    (wb_bte),
        .o_wb_data   (wb_data),
        .o_wb_ack    (wb_ack),
        .o_wb_err    (wb_err),
        .o_fifo_full (fifo_full)
    );

    always #50 clk = ~clk;      // 100 ns period

    // Hang guard
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Timeout, the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Models and helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [63:0] next_expected(input logic mode, input logic [63:0] word);
        if (mode == wb_test_gen_pkg::GEN_MODE_COUNT)
            next_expected = word + 64'd1;                       // Plain count
        else
            next_expected = (word >> 1) ^ (word[0] ? wb_test_gen_pkg::LFSR_TAPS : 64'd0);
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        xorshift32 = s ^ (s << 5);
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected)
        begin
            $display("MISMATCH at %0d ns: %s, got %h, expected %h", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Drive point just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus master running one burst in the style of the row
    //////////////////////////////////////////////////////////////////////
    task automatic run_burst(input row_t cfg);
        int acks       = 0;
        int stalls     = 0;             // Ack-free cycles after the first ack
        int waited     = 0;
        int fault_beat = 0;
        int pause_left = 0;
        bit fault_done = 1'b0;
        bit err_seen   = 1'b0;
        bit bad_sel;
        bit start;
        rng        = xorshift32(rng);
        fault_beat = 1 + int'(rng % (BURST_LEN / 2));   // Beat where the fault starts
        bad_sel    = (cfg.style == STYLE_BAD_SEL);
        wb_sel     = bad_sel ? 8'h0F : 8'hFF;
        wb_cti     = wb_test_gen_pkg::CTI_CONST;
        wb_cyc     = 1'b1;
        wb_stb     = 1'b1;
        while (bad_sel ? (waited < 2 * BURST_LEN) : (acks < BURST_LEN))
        begin
            @(negedge clk);
            waited++;
            if (wb_err)
                err_seen = 1'b1;
            if (wb_ack)
            begin
                check_value(wb_data, exp_word, "ack data");
                exp_word = next_expected(exp_mode, exp_word);
                acks++;
            end
            else if (acks > 0)
                stalls++;
            next_cycle();
            start = !fault_done && (acks >= fault_beat);
            if (start)
            begin
                fault_done = 1'b1;
                if (cfg.pause_max != 0)
                begin
                    rng        = xorshift32(rng);
                    pause_left = 1 + int'(rng % cfg.pause_max);
                end
            end
            gen_en = (pause_left == 0);                     // Starve the FIFO while paused
            if (pause_left > 0)
                pause_left--;
            wb_stb = !(cfg.style == STYLE_STB_GAP && start);
            case (cfg.style)
                STYLE_EARLY_EOB: wb_cti = fault_done ? wb_test_gen_pkg::CTI_EOB :
                                                       wb_test_gen_pkg::CTI_CONST;
                STYLE_NO_EOB:    wb_cti = wb_test_gen_pkg::CTI_CONST;
                default:         wb_cti = (acks >= BURST_LEN - 1) ? wb_test_gen_pkg::CTI_EOB :
                                                                    wb_test_gen_pkg::CTI_CONST;
            endcase
        end
        wb_cyc = 1'b0;      // End of cycle
        wb_stb = 1'b0;
        wb_sel = 8'hFF;
        gen_en = 1'b1;
        // Error on the last beat lands one cycle later
        repeat (2)
        begin
            @(negedge clk);
            if (wb_err)
                err_seen = 1'b1;
            if (wb_ack)
                acks++;
            next_cycle();
        end
        check_value(acks, cfg.exp_acks, "ack count");
        check_value(err_seen, cfg.exp_err, "error flag");
        if (cfg.pause_max != 0)
            check_value(stalls > 0, 1'b1, "ack stall while the FIFO ran empty");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        rst       = 1'b1;
        gen_en    = 1'b1;
        gen_clear = 1'b0;
        gen_mode  = wb_test_gen_pkg::GEN_MODE_COUNT;
        wb_addr   = '0;
        wb_sel    = 8'hFF;
        wb_we     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_cti    = wb_test_gen_pkg::CTI_CONST;
        wb_bte    = wb_test_gen_pkg::BTE_LINEAR;
        exp_word  = '0;
        exp_mode  = wb_test_gen_pkg::GEN_MODE_COUNT;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        @(negedge clk);
        check_value(wb_ack, 1'b0, "ack after reset");
        check_value(wb_err, 1'b0, "err after reset");
        check_value(wb_data, 64'd0, "data after reset");
        next_cycle();
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            row = table_row(r);
            repeat (row.idle)           // Generator runs into back-pressure
            begin
                @(negedge clk);
                check_value(fifo_full, 1'b0, "FIFO full flag while idle");
                next_cycle();
            end
            if (row.clear)
            begin
                gen_clear = 1'b1;
                gen_mode  = row.mode;
                next_cycle();
                gen_clear = 1'b0;
                exp_mode  = row.mode;
                exp_word  = (row.mode == wb_test_gen_pkg::GEN_MODE_LFSR) ?
                            wb_test_gen_pkg::LFSR_SEED : 64'd0;
            end
            run_burst(row);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/wb_test_gen_top.sv */
`default_nettype none

module wb_test_gen_top
(
    input  wire                                  i_clk,
    input  wire                                  i_rst,
    // Generator control
    input  wire                                  i_gen_en,
    input  wire                                  i_gen_clear,   // Also flushes FIFO
    input  wire                                  i_gen_mode,
    // Wishbone burst read slave
    input  wire  [wb_test_gen_pkg::ADDR_W-1:0]   i_wb_addr,
    input  wire  [wb_test_gen_pkg::SEL_W-1:0]    i_wb_sel,
    input  wire                                  i_wb_we,
    input  wire                                  i_wb_cyc,
    input  wire                                  i_wb_stb,
    input  wire  [2:0]                           i_wb_cti,
    input  wire  [1:0]                           i_wb_bte,
    output wire  [wb_test_gen_pkg::DATA_W-1:0]   o_wb_data,
    output wire                                  o_wb_ack,
    output wire                                  o_wb_err,
    // Status
    output wire                                  o_fifo_full
);

    //////////////////////////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////////////////////////
    wire [wb_test_gen_pkg::DATA_W-1:0]  gen_data;       // Generator to FIFO
    wire                                gen_wr;
    wire                                fifo_prog_full; // Back-pressure
    wire [wb_test_gen_pkg::DATA_W-1:0]  fifo_data;      // FIFO to slave
    wire                                fifo_empty;
    wire                                fifo_rd;

    // Stage 1
    test_pattern_gen u_gen
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_gen_en    (i_gen_en),
        .i_gen_clear (i_gen_clear),
        .i_gen_mode  (i_gen_mode),
        .i_prog_full (fifo_prog_full),
        .o_wr_data   (gen_data),
        .o_wr_en     (gen_wr)
    );

    // Stage 2
    test_gen_fifo u_fifo
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_flush     (i_gen_clear),
        .i_wr_en     (gen_wr),
        .i_wr_data   (gen_data),
        .i_rd_en     (fifo_rd),
        .o_rd_data   (fifo_data),
        .o_empty     (fifo_empty),
        .o_full      (o_fifo_full),
        .o_prog_full (fifo_prog_full)
    );

    // Stage 3
    wb_burst_read_slave u_slave
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_wb_addr    (i_wb_addr),
        .i_wb_sel     (i_wb_sel),
        .i_wb_we      (i_wb_we),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_cti     (i_wb_cti),
        .i_wb_bte     (i_wb_bte),
        .o_wb_data    (o_wb_data),
        .o_wb_ack     (o_wb_ack),
        .o_wb_err     (o_wb_err),
        .i_fifo_data  (fifo_data),
        .i_fifo_empty (fifo_empty),
        .o_fifo_rd    (fifo_rd)
    );

endmodule

`default_nettype wire

/* hw/wb_burst_read_slave.sv */
`default_nettype none

module wb_burst_read_slave
(
    input  wire                                  i_clk,
    input  wire                                  i_rst,
    // Read-only Wishbone slave
    input  wire  [wb_test_gen_pkg::ADDR_W-1:0]   i_wb_addr,
    input  wire  [wb_test_gen_pkg::SEL_W-1:0]    i_wb_sel,
    input  wire                                  i_wb_we,
    input  wire                                  i_wb_cyc,
    input  wire                                  i_wb_stb,
    input  wire  [2:0]                           i_wb_cti,
    input  wire  [1:0]                           i_wb_bte,
    output logic [wb_test_gen_pkg::DATA_W-1:0]   o_wb_data,
    output logic                                 o_wb_ack,
    output logic                                 o_wb_err,
    // Test word FIFO
    input  wire  [wb_test_gen_pkg::DATA_W-1:0]   i_fifo_data,   // Cycle after read
    input  wire                                  i_fifo_empty,
    output logic                                 o_fifo_rd
);

    logic                                    req_ok;    // Qualified request
    logic [wb_test_gen_pkg::BEAT_CNT_W-1:0]  rd_cnt;    // Reads issued this cycle
    logic [wb_test_gen_pkg::BEAT_CNT_W-1:0]  ack_cnt;   // Acks given this cycle
    logic                                    rd_q;      // Read one cycle ago
    logic                                    ack_q;     // Registered beat
    logic                                    beat_last;
    logic                                    err_cti;
    logic                                    err_gap;

    //////////////////////////////////////////////////////////////////////
    // Request qualification and FIFO read
    //////////////////////////////////////////////////////////////////////
    assign req_ok = i_wb_cyc && i_wb_stb && !i_wb_we &&
                    (i_wb_addr == '0) &&                        // Fixed start address
                    (i_wb_sel == '1) &&                         // Full 64-bit lanes
                    (i_wb_bte == wb_test_gen_pkg::BTE_LINEAR);

    // Empty FIFO only stalls
    // At most one burst of reads per cycle of cyc
    assign o_fifo_rd = req_ok && !i_fifo_empty &&
        (rd_cnt < wb_test_gen_pkg::BEAT_CNT_W'(wb_test_gen_pkg::BURST_LEN));

    // No beat is shown to a master that has left the bus
    assign o_wb_ack = ack_q && i_wb_cyc;

    //////////////////////////////////////////////////////////////////////
    // Data and ack pipeline with two edges from read to ack
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            rd_q      <= 1'b0;
            ack_q     <= 1'b0;
            o_wb_data <= '0;
        end
        else
        begin
            rd_q  <= o_fifo_rd;
            ack_q <= rd_q;                  // One ack per read
            if (rd_q)
                o_wb_data <= i_fifo_data;   // FIFO word is valid now
        end
    end

    // Beat counters cleared between cycles
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            rd_cnt  <= '0;
            ack_cnt <= '0;
        end
        else if (!i_wb_cyc)
        begin
            rd_cnt  <= '0;
            ack_cnt <= '0;
        end
        else
        begin
            if (o_fifo_rd)
                rd_cnt <= rd_cnt + 1'b1;
            if (o_wb_ack)
                ack_cnt <= ack_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Protocol checks
    //////////////////////////////////////////////////////////////////////
    assign beat_last = (ack_cnt == wb_test_gen_pkg::BEAT_CNT_W'(wb_test_gen_pkg::BURST_LEN - 1));

    // Master must say EOB on exactly the last beat
    assign err_cti = o_wb_ack &&
                     (beat_last ? (i_wb_cti != wb_test_gen_pkg::CTI_EOB) :
                                  (i_wb_cti != wb_test_gen_pkg::CTI_CONST));

    // Wait state inserted by the master once data started
    assign err_gap = i_wb_cyc && !i_wb_stb && (rd_cnt != '0);

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            o_wb_err <= 1'b0;
        else
            o_wb_err <= err_cti || err_gap;     // One cycle per offending cycle
    end

    // Never more reads than one burst
    a_rd_cap : assert property (@(posedge i_clk) disable iff (i_rst)
        rd_cnt <= wb_test_gen_pkg::BEAT_CNT_W'(wb_test_gen_pkg::BURST_LEN));

endmodule

`default_nettype wire

/* hw/test_gen_fifo.sv */
`default_nettype none

module test_gen_fifo
(
    input  wire                                  i_clk,
    input  wire                                  i_rst,
    input  wire                                  i_flush,       // Drop all contents
    input  wire                                  i_wr_en,
    input  wire  [wb_test_gen_pkg::DATA_W-1:0]   i_wr_data,
    input  wire                                  i_rd_en,
    output logic [wb_test_gen_pkg::DATA_W-1:0]   o_rd_data,     // Valid cycle after read
    output logic                                 o_empty,
    output logic                                 o_full,
    output logic                                 o_prog_full
);

    // Word storage
    logic [wb_test_gen_pkg::DATA_W-1:0]  mem [wb_test_gen_pkg::FIFO_DEPTH];

    // Pointers carry one wrap bit above the address
    logic [wb_test_gen_pkg::FIFO_AW:0]   wr_ptr;
    logic [wb_test_gen_pkg::FIFO_AW:0]   rd_ptr;
    logic [wb_test_gen_pkg::FIFO_AW:0]   fill;          // Words held
    logic                                wr_go;
    logic                                rd_go;

    //////////////////////////////////////////////////////////////////////
    // Flags from pointer difference
    //////////////////////////////////////////////////////////////////////
    assign fill        = wr_ptr - rd_ptr;
    assign o_empty     = (fill == '0);
    assign o_full      = (fill == (wb_test_gen_pkg::FIFO_AW + 1)'(wb_test_gen_pkg::FIFO_DEPTH));
    assign o_prog_full =
        (fill >= (wb_test_gen_pkg::FIFO_AW + 1)'(wb_test_gen_pkg::FIFO_PROG_FULL));

    // Flush wins over both ports
    assign wr_go = i_wr_en && !o_full && !i_flush;
    assign rd_go = i_rd_en && !o_empty && !i_flush;

    //////////////////////////////////////////////////////////////////////
    // Pointer control
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else if (i_flush)
        begin
            // Empty in one cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_go)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_go)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Write port
    always_ff @(posedge i_clk)
    begin
        if (wr_go)
            mem[wr_ptr[wb_test_gen_pkg::FIFO_AW-1:0]] <= i_wr_data;
    end

    // Registered read port holds the last word between reads
    always_ff @(posedge i_clk)
    begin
        if (rd_go)
            o_rd_data <= mem[rd_ptr[wb_test_gen_pkg::FIFO_AW-1:0]];
    end

    // Producer and consumer both honour the flags
    a_no_wr_full  : assert property (@(posedge i_clk) disable iff (i_rst)
        (i_wr_en && !i_flush) |-> !o_full);
    a_no_rd_empty : assert property (@(posedge i_clk) disable iff (i_rst)
        i_rd_en |-> !o_empty);

endmodule

`default_nettype wire

/* hw/test_pattern_gen.sv */
`default_nettype none

module test_pattern_gen
(
    input  wire                                  i_clk,
    input  wire                                  i_rst,
    input  wire                                  i_gen_en,      // Run enable
    input  wire                                  i_gen_clear,   // Restart pulse
    input  wire                                  i_gen_mode,    // Taken on clear only
    input  wire                                  i_prog_full,   // FIFO almost full
    output logic [wb_test_gen_pkg::DATA_W-1:0]   o_wr_data,
    output logic                                 o_wr_en
);

    // Step one word forward in the given mode
    function automatic logic [wb_test_gen_pkg::DATA_W-1:0] next_word
    (
        input logic                               mode,
        input logic [wb_test_gen_pkg::DATA_W-1:0] word
    );
        logic [wb_test_gen_pkg::DATA_W-1:0] shifted;
        shifted = word >> 1;
        if (mode == wb_test_gen_pkg::GEN_MODE_LFSR)
        begin
            // Galois step with feedback when the bit shifted out is set
            next_word = word[0] ? (shifted ^ wb_test_gen_pkg::LFSR_TAPS) : shifted;
        end
        else
        begin
            next_word = word + wb_test_gen_pkg::DATA_W'(1);
        end
    endfunction

    logic                                gen_mode;      // Latched mode
    logic [wb_test_gen_pkg::DATA_W-1:0]  gen_word;      // Next word to emit
    logic [wb_test_gen_pkg::DATA_W-1:0]  first_word;    // Start of sequence

    assign first_word = (i_gen_mode == wb_test_gen_pkg::GEN_MODE_LFSR) ?
                        wb_test_gen_pkg::LFSR_SEED : '0;

    //////////////////////////////////////////////////////////////////////
    // Word source with one registered write per cycle while FIFO has room
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_wr_en   <= 1'b0;
            o_wr_data <= '0;
            gen_word  <= '0;
            gen_mode  <= wb_test_gen_pkg::GEN_MODE_COUNT;
        end
        else if (i_gen_clear)
        begin
            // FIFO flushes on this edge so the first word goes out right away
            gen_mode  <= i_gen_mode;
            o_wr_en   <= i_gen_en;
            o_wr_data <= first_word;
            gen_word  <= i_gen_en ? next_word(i_gen_mode, first_word) : first_word;
        end
        else if (i_gen_en && !i_prog_full)
        begin
            o_wr_en   <= 1'b1;
            o_wr_data <= gen_word;
            gen_word  <= next_word(gen_mode, gen_word);   // Advance only on a write
        end
        else
        begin
            o_wr_en   <= 1'b0;                            // Hold word for later
        end
    end

    // LFSR state never collapses to zero
    a_lfsr_nonzero : assert property (@(posedge i_clk) disable iff (i_rst)
        (gen_mode == wb_test_gen_pkg::GEN_MODE_LFSR) |-> (gen_word != '0));

endmodule

`default_nettype wire

/* hw/wb_test_gen_pkg.sv */
`default_nettype none

package wb_test_gen_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus geometry
    //////////////////////////////////////////////////////////////////////
    localparam int DATA_W = 64;         // Test word and bus data width
    localparam int SEL_W  = 8;          // One select bit per byte
    localparam int ADDR_W = 12;         // Bus address width

    // Burst shape, fixed for every transfer
    localparam int BURST_LEN  = 64;     // Beats per burst
    localparam int BEAT_CNT_W = 7;      // Holds 0..BURST_LEN inclusive

    //////////////////////////////////////////////////////////////////////
    // FIFO sizing
    //////////////////////////////////////////////////////////////////////
    localparam int FIFO_DEPTH     = 128;
    localparam int FIFO_AW        = 7;      // log2 of depth
    // Generator pause level, leaves room for the write already in flight
    localparam int FIFO_PROG_FULL = 120;

    //////////////////////////////////////////////////////////////////////
    // Pattern source
    //////////////////////////////////////////////////////////////////////
    // First LFSR word, must be nonzero
    localparam logic [DATA_W-1:0] LFSR_SEED = 64'hACE1_2468_1357_9BDF;
    // Right-shift Galois mask, x^64 + x^63 + x^61 + x^60 + 1
    localparam logic [DATA_W-1:0] LFSR_TAPS = 64'hD800_0000_0000_0000;

    localparam logic GEN_MODE_COUNT = 1'b0;     // 0, 1, 2 ...
    localparam logic GEN_MODE_LFSR  = 1'b1;     // Seed, then Galois steps

    //////////////////////////////////////////////////////////////////////
    // Wishbone cycle and burst type codes
    //////////////////////////////////////////////////////////////////////
    localparam logic [2:0] CTI_CONST  = 3'b001;   // Constant address burst
    localparam logic [2:0] CTI_EOB    = 3'b111;   // End of burst
    localparam logic [1:0] BTE_LINEAR = 2'b00;    // Linear burst

endpackage

`default_nettype wire
